//--- Bender.yml
package:
  name: rv_shell

sources:
  - include_dirs:
      - source
    files:
      - source/rv_rf_pkg.sv
      - source/rv_ic_pkg.sv
      - source/rv_core_clock_ctrl.sv
      - source/rv_regfile_ff.sv
      - source/rv_scr_key_ctrl.sv
      - source/rv_ic_ram_bank.sv
      - source/rv_shell_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_rv_shell_assert.sv
      - test/tb_rv_shell_checker.sv
      - test/tb_rv_shell.sv

//--- rv_shell.f
+incdir+source
source/rv_rf_pkg.sv
source/rv_ic_pkg.sv
source/rv_core_clock_ctrl.sv
source/rv_regfile_ff.sv
source/rv_scr_key_ctrl.sv
source/rv_ic_ram_bank.sv
source/rv_shell_top.sv
test/tb_rv_shell_assert.sv
test/tb_rv_shell_checker.sv
test/tb_rv_shell.sv

//--- source/rv_core_clock_ctrl.sv
// Core clock control with busy register and latch based clock gate
// The gated clock only rises while the wake condition holds or test_en_i is set
// core_sleep_o is combinational from the wake sources

`default_nettype none

module rv_core_clock_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic core_sleep_o,
  output logic gated_clk_o
);

  logic busy_q;
  logic wake;
  logic clk_en_q;

  // Busy is only seen one cycle late
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= core_busy_i;
    end
  end

  assign wake         = busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~wake;

  ////////////////////////////////////////////////////////////////////////////
  // Clock gate
  ////////////////////////////////////////////////////////////////////////////

  // Enable can only change while the clock is low, so no glitches on the AND
  always_latch begin
    if (!clk_i) begin
      clk_en_q <= wake | test_en_i;
    end
  end

  assign gated_clk_o = clk_i & clk_en_q;

endmodule

`default_nettype wire

//--- source/rv_ic_pkg.sv
// Instruction cache geometry and scramble key types
// Sizes come from the shell constants header
// Tag entries pack the valid bit above the tag

`default_nettype none

`include "rv_shell_consts.svh"

package rv_ic_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Cache geometry
  ////////////////////////////////////////////////////////////////////////////

  // Line index inside one bank
  typedef logic [$clog2(`RV_IC_NUM_LINES)-1:0] ic_index_t;

  // One request bit per way
  typedef logic [`RV_IC_NUM_WAYS-1:0] ic_way_vec_t;

  // Tag bank entry
  typedef struct packed {
    logic                    valid;
    logic [`RV_IC_TAG_W-1:0] tag;
  } ic_tag_entry_t;

  // Data bank entry
  typedef logic [`RV_IC_LINE_W-1:0] ic_line_t;

  ////////////////////////////////////////////////////////////////////////////
  // Scramble key material
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [`RV_SCR_KEY_W-1:0]   scr_key_t;
  typedef logic [`RV_SCR_NONCE_W-1:0] scr_nonce_t;

endpackage

`default_nettype wire

//--- source/rv_ic_ram_bank.sv
// Single-port cache RAM bank with XOR keystream scrambling
// Read data appears one cycle after the request and holds until the next read
// Lines written under an old key read back garbled after a rekey

`default_nettype none

`include "rv_shell_consts.svh"

module rv_ic_ram_bank #(
  parameter type payload_t = logic [`RV_IC_LINE_W-1:0]
) (
  input  logic                  clk_i,
  input  logic                  req_i,
  input  logic                  write_i,
  input  rv_ic_pkg::ic_index_t  addr_i,
  input  payload_t              wdata_i,
  input  rv_ic_pkg::scr_key_t   key_i,
  input  rv_ic_pkg::scr_nonce_t nonce_i,
  output payload_t              rdata_o
);

  localparam int unsigned Width  = $bits(payload_t);
  localparam int unsigned KeyW   = `RV_SCR_KEY_W;
  localparam int unsigned NumRep = (Width + KeyW - 1) / KeyW;

  logic [Width-1:0]      mem_q [`RV_IC_NUM_LINES];
  logic [KeyW-1:0]       ks_word;
  logic [NumRep*KeyW-1:0] ks_rep;
  logic [Width-1:0]      keystream;
  payload_t              rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Keystream for the addressed line
  ////////////////////////////////////////////////////////////////////////////

  // Key mixed with doubled nonce, then every byte tweaked by the line index
  assign ks_word   = key_i ^ {2{nonce_i}} ^ {(KeyW / 8){8'(addr_i)}};
  assign ks_rep    = {NumRep{ks_word}};
  assign keystream = ks_rep[Width-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Storage and read register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i && write_i) begin
      mem_q[addr_i] <= wdata_i ^ keystream;
    end
  end

  // Descramble with whatever key is current at read time
  always_ff @(posedge clk_i) begin
    if (req_i && !write_i) begin
      rdata_q <= payload_t'(mem_q[addr_i] ^ keystream);
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- source/rv_regfile_ff.sv
// Flip-flop register file, two combinational reads and one write
// Runs on the gated core clock, so writes while gated are lost
// Register 0 is not stored and always reads zero

`default_nettype none

`include "rv_shell_consts.svh"

module rv_regfile_ff (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  rv_rf_pkg::reg_addr_t raddr_a_i,
  input  rv_rf_pkg::reg_addr_t raddr_b_i,
  input  rv_rf_pkg::reg_addr_t waddr_i,
  input  rv_rf_pkg::reg_data_t wdata_i,
  input  logic                 we_i,
  output rv_rf_pkg::reg_data_t rdata_a_o,
  output rv_rf_pkg::reg_data_t rdata_b_o
);

  localparam int unsigned NumRegs = `RV_NUM_REGS;

  // Per-register write enables, register 0 has none
  logic [NumRegs-1:1] we_dec;

  // Read view of all registers, entry 0 tied off
  rv_rf_pkg::reg_data_t rf_word [NumRegs];

  ////////////////////////////////////////////////////////////////////////////
  // Write address decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int unsigned i = 1; i < NumRegs; i++) begin
      we_dec[i] = we_i & (waddr_i == rv_rf_pkg::reg_addr_t'(i));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  assign rf_word[0] = '0;

  for (genvar r = 1; r < NumRegs; r++) begin : gen_regs
    rv_rf_pkg::reg_data_t rf_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q <= '0;
      end else if (we_dec[r]) begin
        rf_q <= wdata_i;
      end
    end

    assign rf_word[r] = rf_q;
  end

  // Read muxes
  assign rdata_a_o = rf_word[raddr_a_i];
  assign rdata_b_o = rf_word[raddr_b_i];

endmodule

`default_nettype wire

//--- source/rv_rf_pkg.sv
// Register file index and word types
// Sizes come from the shell constants header

`default_nettype none

`include "rv_shell_consts.svh"

package rv_rf_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register file types
  ////////////////////////////////////////////////////////////////////////////

  // Register index, wide enough for all architectural registers
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

  // One register word
  typedef logic [`RV_XLEN-1:0] reg_data_t;

endpackage

`default_nettype wire

//--- source/rv_scr_key_ctrl.sv
// Scramble key request handshake and key/nonce registers
// A request waits as long as the provider needs, there is no timeout
// Key and nonce load on every provider valid, requested or not

`default_nettype none

`include "rv_shell_consts.svh"

module rv_scr_key_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ic_scr_key_req_i,
  input  logic                  scramble_key_valid_i,
  input  rv_ic_pkg::scr_key_t   scramble_key_i,
  input  rv_ic_pkg::scr_nonce_t scramble_nonce_i,
  output logic                  scramble_req_o,
  output logic                  key_valid_o,
  output rv_ic_pkg::scr_key_t   key_o,
  output rv_ic_pkg::scr_nonce_t nonce_o
);

  logic req_d, req_q;
  logic valid_d, valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  // Request starts on a cache invalidate and holds until the provider answers
  assign req_d = req_q ? ~scramble_key_valid_i : ic_scr_key_req_i;

  // Valid drops with a new request and returns with the provider's answer
  assign valid_d = req_q            ? scramble_key_valid_i :
                   ic_scr_key_req_i ? 1'b0                 :
                                      valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q   <= 1'b0;
      valid_q <= 1'b1;
    end else begin
      req_q   <= req_d;
      valid_q <= valid_d;
    end
  end

  // Key material, starts from the built-in defaults
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_o   <= `RV_SCR_KEY_RST;
      nonce_o <= `RV_SCR_NONCE_RST;
    end else if (scramble_key_valid_i) begin
      key_o   <= scramble_key_i;
      nonce_o <= scramble_nonce_i;
    end
  end

  assign scramble_req_o = req_q;
  assign key_valid_o    = valid_q;

endmodule

`default_nettype wire

//--- source/rv_shell_consts.svh
// Width, depth and reset constants shared by the core support shell
// RV_SCR_KEY_W must stay twice RV_SCR_NONCE_W for the keystream rule
// RV_IC_NUM_LINES must not exceed 256 so the line index fits in a byte

`ifndef RV_SHELL_CONSTS_SVH
`define RV_SHELL_CONSTS_SVH

// Register file geometry
`define RV_XLEN     32
`define RV_NUM_REGS 32

// Instruction cache geometry
`define RV_IC_NUM_WAYS  2
`define RV_IC_NUM_LINES 16
`define RV_IC_TAG_W     20
`define RV_IC_LINE_W    64

// Scramble key and nonce widths
`define RV_SCR_KEY_W   32
`define RV_SCR_NONCE_W 16

// Key material used until the provider sends the first key
`define RV_SCR_KEY_RST   32'hA5C3_1E7B
`define RV_SCR_NONCE_RST 16'h3C96

`endif

//--- source/rv_shell_top.sv
// Core support shell, the core side of every link is a top-level port
// Register file runs on the gated clock, cache banks on clk_i
// Cache reads are not gated on key valid, the core side decides that

`default_nettype none

`include "rv_shell_consts.svh"

module rv_shell_top (
  // Clock, reset and wake sources
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     test_en_i,
  input  logic                     core_busy_i,
  input  logic                     debug_req_i,
  input  logic                     irq_pending_i,
  input  logic                     irq_nm_i,
  output logic                     core_sleep_o,

  // Register file
  input  rv_rf_pkg::reg_addr_t     rf_raddr_a_i,
  input  rv_rf_pkg::reg_addr_t     rf_raddr_b_i,
  input  rv_rf_pkg::reg_addr_t     rf_waddr_i,
  input  rv_rf_pkg::reg_data_t     rf_wdata_i,
  input  logic                     rf_we_i,
  output rv_rf_pkg::reg_data_t     rf_rdata_a_o,
  output rv_rf_pkg::reg_data_t     rf_rdata_b_o,

  // Instruction cache RAMs
  input  rv_ic_pkg::ic_way_vec_t   ic_tag_req_i,
  input  rv_ic_pkg::ic_way_vec_t   ic_data_req_i,
  input  logic                     ic_tag_write_i,
  input  logic                     ic_data_write_i,
  input  rv_ic_pkg::ic_index_t     ic_tag_addr_i,
  input  rv_ic_pkg::ic_index_t     ic_data_addr_i,
  input  rv_ic_pkg::ic_tag_entry_t ic_tag_wdata_i,
  input  rv_ic_pkg::ic_line_t      ic_data_wdata_i,
  output rv_ic_pkg::ic_tag_entry_t ic_tag_rdata_o [`RV_IC_NUM_WAYS],
  output rv_ic_pkg::ic_line_t      ic_data_rdata_o [`RV_IC_NUM_WAYS],
  input  logic                     ic_scr_key_req_i,
  output logic                     ic_scr_key_valid_o,

  // Key provider
  input  logic                     scramble_key_valid_i,
  input  rv_ic_pkg::scr_key_t      scramble_key_i,
  input  rv_ic_pkg::scr_nonce_t    scramble_nonce_i,
  output logic                     scramble_req_o
);

  logic                  gated_clk;
  rv_ic_pkg::scr_key_t   scr_key;
  rv_ic_pkg::scr_nonce_t scr_nonce;

  ////////////////////////////////////////////////////////////////////////////
  // Clock control and register file
  ////////////////////////////////////////////////////////////////////////////

  rv_core_clock_ctrl u_clock_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .test_en_i    (test_en_i),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .core_sleep_o (core_sleep_o),
    .gated_clk_o  (gated_clk)
  );

  rv_regfile_ff u_regfile (
    .clk_i    (gated_clk),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .raddr_b_i(rf_raddr_b_i),
    .waddr_i  (rf_waddr_i),
    .wdata_i  (rf_wdata_i),
    .we_i     (rf_we_i),
    .rdata_a_o(rf_rdata_a_o),
    .rdata_b_o(rf_rdata_b_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Scramble key and cache banks
  ////////////////////////////////////////////////////////////////////////////

  rv_scr_key_ctrl u_scr_key_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .ic_scr_key_req_i    (ic_scr_key_req_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .key_valid_o         (ic_scr_key_valid_o),
    .key_o               (scr_key),
    .nonce_o             (scr_nonce)
  );

  for (genvar way = 0; way < `RV_IC_NUM_WAYS; way++) begin : gen_ways
    rv_ic_ram_bank #(.payload_t(rv_ic_pkg::ic_tag_entry_t)) u_tag_bank (
      .clk_i  (clk_i),
      .req_i  (ic_tag_req_i[way]),
      .write_i(ic_tag_write_i),
      .addr_i (ic_tag_addr_i),
      .wdata_i(ic_tag_wdata_i),
      .key_i  (scr_key),
      .nonce_i(scr_nonce),
      .rdata_o(ic_tag_rdata_o[way])
    );

    rv_ic_ram_bank #(.payload_t(rv_ic_pkg::ic_line_t)) u_data_bank (
      .clk_i  (clk_i),
      .req_i  (ic_data_req_i[way]),
      .write_i(ic_data_write_i),
      .addr_i (ic_data_addr_i),
      .wdata_i(ic_data_wdata_i),
      .key_i  (scr_key),
      .nonce_i(scr_nonce),
      .rdata_o(ic_data_rdata_o[way])
    );
  end

endmodule

`default_nettype wire

//--- test/tb_rv_shell.sv
// Testbench for the core support shell, one stimulus row per clock cycle
// Comparing happens in the checker, the key handshake is also asserted
// Inputs change 1 ns after the rising clock edge

`default_nettype none

`include "rv_shell_consts.svh"

module tb_rv_shell;

  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [2:0] {
    OP_IDLE, OP_RF_WR, OP_RF_RD, OP_TAG_WR, OP_DATA_WR, OP_IC_RD, OP_KEY_REQ
  } op_e;

  // Wake bits are debug, irq pending and nmi
  typedef struct {
    op_e         op;
    logic [4:0]  addr;
    logic [63:0] data;
    logic [1:0]  ways;
    logic        busy;
    logic [2:0]  wake;
    logic        kvalid;
    logic [31:0] key;
    logic [15:0] nonce;
  } row_t;

  logic clk_i, rst_ni, test_en_i, core_busy_i, debug_req_i, irq_pending_i, irq_nm_i;
  logic core_sleep_o, rf_we_i, ic_tag_write_i, ic_data_write_i;
  logic ic_scr_key_req_i, ic_scr_key_valid_o, scramble_key_valid_i, scramble_req_o;
  rv_rf_pkg::reg_addr_t     rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i;
  rv_rf_pkg::reg_data_t     rf_wdata_i, rf_rdata_a_o, rf_rdata_b_o;
  rv_ic_pkg::ic_way_vec_t   ic_tag_req_i, ic_data_req_i;
  rv_ic_pkg::ic_index_t     ic_tag_addr_i, ic_data_addr_i;
  rv_ic_pkg::ic_tag_entry_t ic_tag_wdata_i;
  rv_ic_pkg::ic_line_t      ic_data_wdata_i;
  rv_ic_pkg::ic_tag_entry_t ic_tag_rdata_o [`RV_IC_NUM_WAYS];
  rv_ic_pkg::ic_line_t      ic_data_rdata_o [`RV_IC_NUM_WAYS];
  rv_ic_pkg::scr_key_t      scramble_key_i;
  rv_ic_pkg::scr_nonce_t    scramble_nonce_i;

  row_t        rows [$];
  logic [4:0]  wr_addr [$];
  logic [15:0] lfsr_q;
  logic        cur_busy;
  logic [2:0]  cur_wake;
  int unsigned cycles = 0;
  int unsigned limit = 0;
  int unsigned value_errs, assert_errs;

  rv_shell_top UUT (.*);

  tb_rv_shell_checker u_checker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .err_cnt_o(value_errs)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [63:0] lfsr_bits(input int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v      = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic add_row(input op_e op, input logic [4:0] addr, input logic [63:0] data,
                         input logic [1:0] ways, input logic kvalid = 1'b0,
                         input logic [31:0] key = '0, input logic [15:0] nonce = '0);
    row_t r;
    r = '{op, addr, data, ways, cur_busy, cur_wake, kvalid, key, nonce};
    rows.push_back(r);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    logic [4:0]  a;
    logic [31:0] k;
    logic [15:0] n;
    cur_busy = 1'b0;
    cur_wake = 3'b000;
    // Reset state, then each wake source alone
    repeat (3) add_row(OP_IDLE, '0, '0, '0);
    for (int i = 0; i < 3; i++) begin
      cur_wake = 3'(1 << i);
      add_row(OP_IDLE, '0, '0, '0);
    end
    cur_wake = 3'b000;
    cur_busy = 1'b1;
    add_row(OP_IDLE, '0, '0, '0);
    for (int i = 0; i < 8; i++) begin
      a = 5'(lfsr_bits(5));
      wr_addr.push_back(a);
      add_row(OP_RF_WR, a, lfsr_bits(32), '0);
      add_row(OP_RF_RD, a, 64'(a), '0);
    end
    add_row(OP_RF_WR, 5'd0, lfsr_bits(32), '0);
    add_row(OP_RF_RD, 5'd0, 64'(wr_addr[0]), '0);
    // Busy falls, the write after it hits a closed clock gate
    cur_busy = 1'b0;
    add_row(OP_IDLE, '0, '0, '0);
    add_row(OP_RF_WR, wr_addr[1], lfsr_bits(32), '0);
    add_row(OP_RF_RD, wr_addr[1], 64'(wr_addr[2]), '0);
    // Cache fill of both ways, then reads of both ways at once
    for (int w = 0; w < 2; w++) begin
      add_row(OP_TAG_WR, 5'd3, lfsr_bits(21), 2'(1 << w));
      add_row(OP_TAG_WR, 5'd9, lfsr_bits(21), 2'(1 << w));
      add_row(OP_DATA_WR, 5'd3, lfsr_bits(64), 2'(1 << w));
      add_row(OP_DATA_WR, 5'd9, lfsr_bits(64), 2'(1 << w));
    end
    add_row(OP_IC_RD, 5'd3, '0, 2'b11);
    add_row(OP_IC_RD, 5'd9, '0, 2'b11);
    add_row(OP_IC_RD, 5'd3, '0, 2'b01);
    // Rekey with a slow provider
    add_row(OP_KEY_REQ, '0, '0, '0);
    repeat (4) add_row(OP_IDLE, '0, '0, '0);
    k = 32'(lfsr_bits(32));
    n = 16'(lfsr_bits(16));
    add_row(OP_IDLE, '0, '0, '0, 1'b1, k, n);
    add_row(OP_IDLE, '0, '0, '0);
    add_row(OP_IC_RD, 5'd3, '0, 2'b11);
    add_row(OP_DATA_WR, 5'd9, lfsr_bits(64), 2'b10);
    add_row(OP_IC_RD, 5'd9, '0, 2'b11);
    repeat (2) add_row(OP_IDLE, '0, '0, '0);
  endtask

  task automatic drive_row(input row_t r);
    core_busy_i          = r.busy;
    {debug_req_i, irq_pending_i, irq_nm_i} = r.wake;
    rf_we_i              = (r.op == OP_RF_WR);
    rf_waddr_i           = r.addr;
    rf_wdata_i           = r.data[31:0];
    rf_raddr_a_i         = r.addr;
    rf_raddr_b_i         = (r.op == OP_RF_RD) ? r.data[4:0] : r.addr;
    ic_tag_req_i         = (r.op inside {OP_TAG_WR, OP_IC_RD}) ? r.ways : '0;
    ic_data_req_i        = (r.op inside {OP_DATA_WR, OP_IC_RD}) ? r.ways : '0;
    ic_tag_write_i       = (r.op == OP_TAG_WR);
    ic_data_write_i      = (r.op == OP_DATA_WR);
    ic_tag_addr_i        = r.addr[3:0];
    ic_data_addr_i       = r.addr[3:0];
    ic_tag_wdata_i       = rv_ic_pkg::ic_tag_entry_t'(r.data[20:0]);
    ic_data_wdata_i      = r.data;
    ic_scr_key_req_i     = (r.op == OP_KEY_REQ);
    scramble_key_valid_i = r.kvalid;
    scramble_key_i       = r.key;
    scramble_nonce_i     = r.nonce;
  endtask

  initial begin
    test_en_i = 1'b0;
    rst_ni    = 1'b0;
    lfsr_q    = 16'd53;
    build_table();
    limit = rows.size() * 2 + 16 + 50;
    drive_row(rows[0]);
    repeat (16) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    foreach (rows[i]) begin
      @(posedge clk_i);
      #1;
      drive_row(rows[i]);
    end
    @(posedge clk_i);
    @(negedge clk_i);
    #1;
    assert_errs = tb_rv_shell.UUT.u_scr_key_ctrl.u_assert.fail_cnt;
    $display("Checks done, %0d value errors, %0d assertion failures",
             value_errs, assert_errs);
    if (value_errs == 0 && assert_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles, the stimulus did not complete", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- test/tb_rv_shell_assert.sv
// Key handshake properties, bound into every key controller instance
// Only checked while out of reset

`default_nettype none

module tb_rv_shell_assert (
  input logic clk_i,
  input logic rst_ni,
  input logic key_req_i,
  input logic provider_valid_i,
  input logic req_i,
  input logic key_valid_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  // Request holds until the provider answers
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !provider_valid_i |=> req_i)
  else begin
    fail_cnt++;
    $error("Key request dropped before the provider answered");
  end

  // Key is never valid while a request is outstanding
  valid_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !key_valid_i)
  else begin
    fail_cnt++;
    $error("Key valid high during an open key request");
  end

  // Requests only start from a cache invalidate
  req_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(req_i) |-> $past(key_req_i))
  else begin
    fail_cnt++;
    $error("Key request rose without a cache key request");
  end

endmodule

bind rv_scr_key_ctrl tb_rv_shell_assert u_assert (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .key_req_i       (ic_scr_key_req_i),
  .provider_valid_i(scramble_key_valid_i),
  .req_i           (scramble_req_o),
  .key_valid_i     (key_valid_o)
);

`default_nettype wire

//--- test/tb_rv_shell_checker.sv
// Scoreboard for the core support shell, samples on the falling clock edge
// Watches the DUT ports through tb_rv_shell.UUT
// Keystream model assumes 32-bit keys and lines of at most 64 bits

`default_nettype none

`include "rv_shell_consts.svh"

module tb_rv_shell_checker (
  input  logic        clk_i,
  input  logic        rst_ni,
  output int unsigned err_cnt_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned Ways  = `RV_IC_NUM_WAYS;
  localparam int unsigned Lines = `RV_IC_NUM_LINES;
  localparam int unsigned TagW  = $bits(rv_ic_pkg::ic_tag_entry_t);

  rv_rf_pkg::reg_data_t  regs_m [`RV_NUM_REGS];
  logic [TagW-1:0]       tag_raw [Ways][Lines];
  logic [TagW-1:0]       tag_exp [Ways];
  rv_ic_pkg::ic_line_t   data_raw [Ways][Lines];
  rv_ic_pkg::ic_line_t   data_exp [Ways];
  logic [Ways-1:0]       tag_rd, data_rd;
  logic                  busy_m, wake_m, req_m, valid_m;
  rv_ic_pkg::scr_key_t   key_m;
  rv_ic_pkg::scr_nonce_t nonce_m;
  logic [63:0]           ks_tag, ks_data;
  int unsigned           errs = 0;

  assign err_cnt_o = errs;

  // Key XOR doubled nonce, each byte XOR line index, word repeated upward
  function automatic logic [63:0] keystream(input rv_ic_pkg::scr_key_t key,
                                            input rv_ic_pkg::scr_nonce_t nonce,
                                            input rv_ic_pkg::ic_index_t idx);
    logic [31:0] word;
    word = key ^ {nonce, nonce};
    for (int b = 0; b < 4; b++) begin
      word[8*b +: 8] = word[8*b +: 8] ^ 8'(idx);
    end
    return {word, word};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
      errs++;
    end
  endtask

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      foreach (regs_m[r]) begin
        regs_m[r] = '0;
      end
      tag_rd  = '0;
      data_rd = '0;
      busy_m  = 1'b0;
      req_m   = 1'b0;
      valid_m = 1'b1;
      key_m   = `RV_SCR_KEY_RST;
      nonce_m = `RV_SCR_NONCE_RST;
    end else begin
      wake_m = busy_m | tb_rv_shell.UUT.debug_req_i | tb_rv_shell.UUT.irq_pending_i |
               tb_rv_shell.UUT.irq_nm_i;

      ////////////////////////////////////////////////////////////////////////
      // Outputs against the model
      ////////////////////////////////////////////////////////////////////////

      check_value("core_sleep_o", 64'(tb_rv_shell.UUT.core_sleep_o), 64'(!wake_m));
      check_value("rf_rdata_a_o", 64'(tb_rv_shell.UUT.rf_rdata_a_o),
                  64'(regs_m[tb_rv_shell.UUT.rf_raddr_a_i]));
      check_value("rf_rdata_b_o", 64'(tb_rv_shell.UUT.rf_rdata_b_o),
                  64'(regs_m[tb_rv_shell.UUT.rf_raddr_b_i]));
      check_value("scramble_req_o", 64'(tb_rv_shell.UUT.scramble_req_o), 64'(req_m));
      check_value("ic_scr_key_valid_o", 64'(tb_rv_shell.UUT.ic_scr_key_valid_o),
                  64'(valid_m));
      for (int w = 0; w < Ways; w++) begin
        if (tag_rd[w]) begin
          check_value($sformatf("ic_tag_rdata_o[%0d]", w),
                      64'(tb_rv_shell.UUT.ic_tag_rdata_o[w]), 64'(tag_exp[w]));
        end
        if (data_rd[w]) begin
          check_value($sformatf("ic_data_rdata_o[%0d]", w),
                      64'(tb_rv_shell.UUT.ic_data_rdata_o[w]), 64'(data_exp[w]));
        end
      end

      ////////////////////////////////////////////////////////////////////////
      // Effect of this cycle's inputs at the next rising edge
      ////////////////////////////////////////////////////////////////////////

      // Gated clock only ticks while awake or in test mode
      if (tb_rv_shell.UUT.rf_we_i && (wake_m || tb_rv_shell.UUT.test_en_i) &&
          tb_rv_shell.UUT.rf_waddr_i != '0) begin
        regs_m[tb_rv_shell.UUT.rf_waddr_i] = tb_rv_shell.UUT.rf_wdata_i;
      end
      busy_m  = tb_rv_shell.UUT.core_busy_i;
      ks_tag  = keystream(key_m, nonce_m, tb_rv_shell.UUT.ic_tag_addr_i);
      ks_data = keystream(key_m, nonce_m, tb_rv_shell.UUT.ic_data_addr_i);
      for (int w = 0; w < Ways; w++) begin
        if (tb_rv_shell.UUT.ic_tag_req_i[w] && tb_rv_shell.UUT.ic_tag_write_i) begin
          tag_raw[w][tb_rv_shell.UUT.ic_tag_addr_i] =
            tb_rv_shell.UUT.ic_tag_wdata_i ^ ks_tag[TagW-1:0];
        end else if (tb_rv_shell.UUT.ic_tag_req_i[w]) begin
          tag_exp[w] = tag_raw[w][tb_rv_shell.UUT.ic_tag_addr_i] ^ ks_tag[TagW-1:0];
          tag_rd[w]  = 1'b1;
        end
        if (tb_rv_shell.UUT.ic_data_req_i[w] && tb_rv_shell.UUT.ic_data_write_i) begin
          data_raw[w][tb_rv_shell.UUT.ic_data_addr_i] =
            tb_rv_shell.UUT.ic_data_wdata_i ^ ks_data;
        end else if (tb_rv_shell.UUT.ic_data_req_i[w]) begin
          data_exp[w] = data_raw[w][tb_rv_shell.UUT.ic_data_addr_i] ^ ks_data;
          data_rd[w]  = 1'b1;
        end
      end

      // Key handshake and key capture
      if (req_m) begin
        if (tb_rv_shell.UUT.scramble_key_valid_i) begin
          req_m   = 1'b0;
          valid_m = 1'b1;
        end
      end else if (tb_rv_shell.UUT.ic_scr_key_req_i) begin
        req_m   = 1'b1;
        valid_m = 1'b0;
      end
      if (tb_rv_shell.UUT.scramble_key_valid_i) begin
        key_m   = tb_rv_shell.UUT.scramble_key_i;
        nonce_m = tb_rv_shell.UUT.scramble_nonce_i;
      end
    end
  end

endmodule

`default_nettype wire
